// File: files.f
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/instr_decoder.sv
rtl/core_fsm.sv
rtl/pc_counter.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/word_mem.sv
rtl/rv_mc_core.sv
verif/rv_mc_core_chk.sv
verif/tb_rv_mc_core.sv

// File: rtl/core_fsm.sv
`timescale 1ns/1ns

module core_fsm (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      run,
    input  logic                      mem_read,
    input  logic                      mem_write,
    output core_pkg::core_state_e     state,
    output logic                      ir_load,
    output logic                      pc_update,
    output logic                      rf_we,
    output logic                      dmem_we,
    output logic                      retire
);
    import core_pkg::*;

    core_state_e next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (run) begin
                    next_state = st_fetch;
                end
            end
            st_fetch: next_state = st_decode;
            st_decode: next_state = st_execute;
            st_execute: begin
                // Loads and stores take the extra memory cycle
                if (mem_read || mem_write) begin
                    next_state = st_memory;
                end else begin
                    next_state = st_writeback;
                end
            end
            st_memory: next_state = st_writeback;
            st_writeback: begin
                next_state = run ? st_fetch : st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    // Strobes, each active in a single state
    assign ir_load   = (state == st_decode);
    assign dmem_we   = (state == st_memory) && mem_write;
    assign pc_update = (state == st_writeback);
    assign rf_we     = (state == st_writeback);
    assign retire    = (state == st_writeback);

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

    // Datapath word, also used for byte addresses
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] reg_addr_t;

    // Multicycle sequencing
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } core_state_e;

endpackage

// File: rtl/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  core_pkg::word_t       pc,
    input  rv_isa_pkg::instr_t    instr,
    input  rv_isa_pkg::encoding_e encoding,
    input  rv_isa_pkg::alu_op_e   alu_op,
    input  logic                  alu_src,
    input  logic                  is_branch,
    input  core_pkg::word_t       rdata1,
    input  core_pkg::word_t       rdata2,
    output core_pkg::word_t       alu_result,
    output core_pkg::word_t       link_value,
    output core_pkg::word_t       next_pc
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    opcode_t opcode;
    word_t   imm;
    word_t   operand_b;
    word_t   sum;
    word_t   pc_plus_imm;
    logic    take_branch;

    assign opcode = instr[6:0];

    always_comb begin
        case (encoding)
            i_type:  imm = {{20{instr[31]}}, instr[31:20]};
            s_type:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            b_type:  imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            u_type:  imm = {instr[31:12], 12'b0};
            j_type:  imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign operand_b   = alu_src ? imm : rdata2;
    assign sum         = (alu_op == alu_sub) ? rdata1 - operand_b : rdata1 + operand_b;
    assign pc_plus_imm = pc + imm;
    assign link_value  = pc + 32'd4;

    always_comb begin
        if (opcode == op_lui) begin
            alu_result = imm;
        end else if (opcode == op_auipc) begin
            alu_result = pc_plus_imm;
        end else begin
            alu_result = sum;
        end
    end

    // Only funct3 000 compares, via the zero result of the subtract
    assign take_branch = (encoding == b_type) && (instr[14:12] == 3'b000) && (sum == '0);

    always_comb begin
        next_pc = link_value;
        if (is_branch) begin
            if (encoding == j_type || take_branch) begin
                next_pc = pc_plus_imm;
            end else if (encoding == i_type) begin
                // JALR target with bit 0 cleared
                next_pc = {sum[31:1], 1'b0};
            end
        end
    end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ir_load,
    input  rv_isa_pkg::instr_t    mem_word,
    output rv_isa_pkg::instr_t    instr,
    output logic                  reg_write,
    output logic                  alu_src,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  mem_to_reg,
    output logic                  is_branch,
    output rv_isa_pkg::encoding_e encoding,
    output rv_isa_pkg::alu_op_e   alu_op
);
    import rv_isa_pkg::*;

    localparam funct7_t funct7_sub = 7'b0100000;
    localparam funct3_t funct3_beq = 3'b000;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    // Instruction register, a zero word decodes to no control activity
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr <= '0;
        end else if (ir_load) begin
            instr <= mem_word;
        end
    end

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        reg_write  = 1'b0;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        is_branch  = 1'b0;
        encoding   = r_type;

        case (opcode)
            op_r: begin
                encoding  = r_type;
                reg_write = 1'b1;
            end
            op_imm: begin
                encoding  = i_type;
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            op_load: begin
                encoding   = i_type;
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            op_store: begin
                encoding  = s_type;
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            op_branch: begin
                encoding  = b_type;
                is_branch = 1'b1;
            end
            // Jumps also write the link register
            op_jalr: begin
                encoding  = i_type;
                is_branch = 1'b1;
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            op_jal: begin
                encoding  = j_type;
                is_branch = 1'b1;
                reg_write = 1'b1;
            end
            op_lui, op_auipc: begin
                encoding  = u_type;
                reg_write = 1'b1;
            end
            default: begin
                encoding = r_type;
            end
        endcase

        // Everything else falls back to add
        alu_op = alu_add;
        if (opcode == op_r && funct3 == 3'b000 && funct7 == funct7_sub) begin
            alu_op = alu_sub;
        end else if (opcode == op_branch && funct3 == funct3_beq) begin
            alu_op = alu_sub;
        end
    end

endmodule

// File: rtl/pc_counter.sv
`timescale 1ns/1ns

module pc_counter #(
    parameter int IMEM_AW = 5
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            pc_update,
    input  core_pkg::word_t next_pc,
    output core_pkg::word_t pc
);
    import core_pkg::*;

    // Upper bits dropped so the pc wraps over the instruction memory
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (pc_update) begin
            pc <= word_t'(next_pc[IMEM_AW+1:0]);
        end
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                we,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero regardless of contents
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Instruction word and its fields
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Major opcodes of the supported RV32I subset
    localparam opcode_t op_r      = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;

    // Instruction format, selects the immediate layout
    typedef enum logic [2:0] {
        r_type,
        i_type,
        s_type,
        b_type,
        u_type,
        j_type
    } encoding_e;

    typedef enum logic {
        alu_add,
        alu_sub
    } alu_op_e;

endpackage

// File: rtl/rv_mc_core.sv
`timescale 1ns/1ns

module rv_mc_core #(
    parameter int IMEM_AW = 5,
    parameter int DMEM_AW = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,
    input  logic                load_we,
    input  logic [IMEM_AW-1:0]  load_addr,
    input  rv_isa_pkg::instr_t  load_data,
    output logic                retire,
    output core_pkg::word_t     retire_pc,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::word_t     retire_data,
    output logic                store_we,
    output core_pkg::word_t     store_addr,
    output core_pkg::word_t     store_data
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    core_state_e state;
    logic        ir_load;
    logic        pc_update;
    logic        rf_we;
    logic        dmem_we;
    logic        reg_write;
    logic        alu_src;
    logic        mem_read;
    logic        mem_write;
    logic        mem_to_reg;
    logic        is_branch;
    encoding_e   encoding;
    alu_op_e     alu_op;
    instr_t      imem_word;
    instr_t      instr;
    word_t       pc;
    word_t       next_pc;
    word_t       rdata1;
    word_t       rdata2;
    word_t       alu_result;
    word_t       link_value;
    word_t       dmem_rdata;
    word_t       wb_data;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    core_fsm i_core_fsm (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .state     (state),
        .ir_load   (ir_load),
        .pc_update (pc_update),
        .rf_we     (rf_we),
        .dmem_we   (dmem_we),
        .retire    (retire)
    );

    pc_counter #(.IMEM_AW(IMEM_AW)) i_pc_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .pc_update (pc_update),
        .next_pc   (next_pc),
        .pc        (pc)
    );

    // Instruction memory, written only from the load port while idle
    word_mem #(.AW(IMEM_AW)) i_imem (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (load_we && state == st_idle),
        .waddr  (load_addr),
        .raddr  (pc[IMEM_AW+1:2]),
        .wdata  (load_data),
        .rdata  (imem_word)
    );

    instr_decoder i_instr_decoder (
        .clk        (clk),
        .arst_n     (arst_n),
        .ir_load    (ir_load),
        .mem_word   (imem_word),
        .instr      (instr),
        .reg_write  (reg_write),
        .alu_src    (alu_src),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .is_branch  (is_branch),
        .encoding   (encoding),
        .alu_op     (alu_op)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (rf_we && reg_write),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exec_unit i_exec_unit (
        .pc         (pc),
        .instr      (instr),
        .encoding   (encoding),
        .alu_op     (alu_op),
        .alu_src    (alu_src),
        .is_branch  (is_branch),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .alu_result (alu_result),
        .link_value (link_value),
        .next_pc    (next_pc)
    );

    word_mem #(.AW(DMEM_AW)) i_dmem (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (dmem_we),
        .waddr  (alu_result[DMEM_AW+1:2]),
        .raddr  (alu_result[DMEM_AW+1:2]),
        .wdata  (rdata2),
        .rdata  (dmem_rdata)
    );

    // Write-back select, jumps are the branches that write a register
    always_comb begin
        if (mem_to_reg) begin
            wb_data = dmem_rdata;
        end else if (is_branch && reg_write) begin
            wb_data = link_value;
        end else begin
            wb_data = alu_result;
        end
    end

    assign retire_pc   = pc;
    assign retire_rd   = reg_write ? rd : '0;
    assign retire_data = (retire_rd == '0) ? '0 : wb_data;

    assign store_we   = dmem_we;
    assign store_addr = alu_result;
    assign store_data = rdata2;

endmodule

// File: rtl/word_mem.sv
`timescale 1ns/1ns

module word_mem #(
    parameter int AW = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            we,
    input  logic [AW-1:0]   waddr,
    input  logic [AW-1:0]   raddr,
    input  core_pkg::word_t wdata,
    output core_pkg::word_t rdata
);
    import core_pkg::*;

    word_t mem [2**AW];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**AW; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) begin
                mem[waddr] <= wdata;
            end
            // Registered read, old data on a same-address write
            rdata <= mem[raddr];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_rv_mc_core

status=0
./obj_dir/Vtb_rv_mc_core > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished cleanly"

// File: verif/rv_mc_core_chk.sv
`timescale 1ns/1ns

module rv_mc_core_chk (
    input logic                  clk,
    input logic                  arst_n,
    input core_pkg::core_state_e state,
    input logic                  dmem_we,
    input logic                  retire
);
    import core_pkg::*;

    // Writeback either starts the next fetch or parks the core
    wb_then_fetch_or_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (state == st_writeback) |=> (state == st_fetch || state == st_idle))
        else $error("writeback not followed by fetch or idle");

    dmem_we_in_memory: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> (state == st_memory))
        else $error("data memory write outside the memory state");

    retire_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        retire |=> !retire)
        else $error("retire high on two consecutive cycles");

    idle_after_reset: assert property (@(posedge clk)
        !arst_n |=> (state == st_idle))
        else $error("core not idle after reset");

endmodule

bind core_fsm rv_mc_core_chk i_rv_mc_core_chk (
    .clk     (clk),
    .arst_n  (arst_n),
    .state   (state),
    .dmem_we (dmem_we),
    .retire  (retire)
);

// File: verif/tb_rv_mc_core.sv
`timescale 1ns/1ns

module tb_rv_mc_core;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int imem_aw = 5;
    localparam int dmem_aw = 4;
    localparam int prog_words = 2**imem_aw;
    localparam int dmem_words = 2**dmem_aw;
    localparam int num_retires = 300;
    localparam int timeout_cycles = num_retires * 5 + prog_words + 100;
    localparam word_t pc_mask = word_t'(prog_words * 4 - 1);

    logic               clk = 1'b0;
    logic               arst_n;
    logic               run;
    logic               load_we;
    logic [imem_aw-1:0] load_addr;
    instr_t             load_data;
    logic               retire;
    word_t              retire_pc;
    reg_addr_t          retire_rd;
    word_t              retire_data;
    logic               store_we;
    word_t              store_addr;
    word_t              store_data;

    // Reference model state
    instr_t      prog [prog_words];
    word_t       model_regs [32];
    word_t       model_dmem [dmem_words];
    word_t       mpc;
    logic        store_seen;
    int          retire_count;
    int          cycle_count = 0;
    logic [31:0] rng_state;

    rv_mc_core #(.IMEM_AW(imem_aw), .DMEM_AW(dmem_aw)) i_rv_mc_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .load_we     (load_we),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .retire      (retire),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .store_we    (store_we),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure(string what);
        $display("tests failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(string name, word_t got, word_t expected);
        if (got !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, got, expected);
            stop_with_failure($sformatf("mismatch on %s", name));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            stop_with_failure("timeout, the core stopped retiring instructions");
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // One random instruction, registers limited to x0..x7
    function automatic instr_t build_instr();
        logic [31:0] r;
        logic [31:0] sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [20:0] imm21;
        funct3_t     f3;
        funct7_t     f7;
        instr_t      w;
        r = next_random();
        sel = next_random() % 32'd10;
        rd = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3 = r[11:9];
        f7 = r[18:12];
        imm12 = {{4{r[27]}}, r[27:20]};
        // Word multiples for branch and jump offsets
        imm13 = {{6{r[24]}}, r[24:20], 2'b00};
        imm21 = {{14{r[24]}}, r[24:20], 2'b00};
        case (sel)
            0: w = r[31] ? {f7, rs2, rs1, f3, rd, op_r}
                         : {7'b0000000, rs2, rs1, 3'b000, rd, op_r};
            1: w = {7'b0100000, rs2, rs1, 3'b000, rd, op_r};
            2: w = {imm12, rs1, r[31] ? f3 : 3'b000, rd, op_imm};
            3: w = {imm12, rs1, 3'b010, rd, op_load};
            4: w = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], op_store};
            5: w = {imm13[12], imm13[10:5], rs2, rs1, r[31] ? f3 : 3'b000,
                    imm13[4:1], imm13[11], op_branch};
            6: w = {r[31:12], rd, op_lui};
            7: w = {r[31:12], rd, op_auipc};
            8: w = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, op_jal};
            default: w = {imm13[11:0], rs1, 3'b000, rd, op_jalr};
        endcase
        return w;
    endfunction

    task automatic check_store();
        instr_t w;
        word_t  imm_s;
        w = prog[mpc[imem_aw+1:2]];
        if (w[6:0] != op_store) begin
            stop_with_failure("store pulse for an instruction that is not SW");
        end else begin
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            check_value("store_addr", store_addr, model_regs[w[19:15]] + imm_s);
            check_value("store_data", store_data, model_regs[w[24:20]]);
            store_seen = 1'b1;
        end
    endtask

    // Executes one instruction in the model and compares the retire outputs
    task automatic check_retire();
        instr_t    w;
        word_t     a;
        word_t     b;
        word_t     res;
        word_t     nxt;
        word_t     addr;
        word_t     imm_i;
        word_t     imm_s;
        word_t     imm_b;
        word_t     imm_u;
        word_t     imm_j;
        reg_addr_t rd;
        logic      writes;
        w = prog[mpc[imem_aw+1:2]];
        a = model_regs[w[19:15]];
        b = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        rd = w[11:7];
        res = '0;
        writes = 1'b1;
        nxt = mpc + 32'd4;
        case (w[6:0])
            op_r: res = (w[14:12] == 3'b000 && w[31:25] == 7'b0100000) ? a - b : a + b;
            op_imm: res = a + imm_i;
            op_load: begin
                addr = a + imm_i;
                res = model_dmem[addr[dmem_aw+1:2]];
            end
            op_store: begin
                writes = 1'b0;
                addr = a + imm_s;
                model_dmem[addr[dmem_aw+1:2]] = b;
                if (!store_seen) begin
                    stop_with_failure("SW retired without a store pulse");
                end
            end
            op_branch: begin
                writes = 1'b0;
                if (w[14:12] == 3'b000 && a == b) begin
                    nxt = mpc + imm_b;
                end
            end
            op_jal: begin
                res = mpc + 32'd4;
                nxt = mpc + imm_j;
            end
            op_jalr: begin
                res = mpc + 32'd4;
                nxt = (a + imm_i) & 32'hFFFF_FFFE;
            end
            op_lui: res = imm_u;
            op_auipc: res = mpc + imm_u;
            default: writes = 1'b0;
        endcase
        if (!writes) begin
            rd = '0;
        end
        check_value("retire_pc", retire_pc, mpc);
        check_value("retire_rd", {27'b0, retire_rd}, {27'b0, rd});
        check_value("retire_data", retire_data, (rd == '0) ? '0 : res);
        if (rd != '0) begin
            model_regs[rd] = res;
        end
        mpc = nxt & pc_mask;
        store_seen = 1'b0;
    endtask

    task automatic sample_outputs();
        if (store_we) begin
            check_store();
        end
        if (retire) begin
            check_retire();
            retire_count++;
        end
    endtask

    initial begin
        arst_n = 1'b0;
        run = 1'b0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        rng_state = 32'd63;
        mpc = '0;
        store_seen = 1'b0;
        retire_count = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            model_dmem[i] = '0;
        end
        for (int i = 0; i < prog_words; i++) begin
            prog[i] = build_instr();
        end

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Program load while the core sits idle
        for (int i = 0; i < prog_words; i++) begin
            @(posedge clk);
            load_we <= 1'b1;
            load_addr <= i[imem_aw-1:0];
            load_data <= prog[i];
        end
        @(posedge clk);
        load_we <= 1'b0;
        run <= 1'b1;

        while (retire_count < num_retires) begin
            @(negedge clk);
            sample_outputs();
        end

        // The instruction fetched after this edge must still complete
        @(posedge clk);
        run <= 1'b0;
        while (retire_count < num_retires + 1) begin
            @(negedge clk);
            sample_outputs();
        end
        repeat (20) begin
            @(negedge clk);
            if (retire || store_we) begin
                stop_with_failure("core kept executing after run was lowered");
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule
